//--- bench/tb_ulpi_link.sv
`timescale 1ns/100ps
`include "ulpi_settings.svh"

module tb_ulpi_link;
	import ulpi_pkg::*;

	logic clk = 1'b0;
	logic rst;
	logic [7:0] ulpi_data_i, ulpi_data_o, phyreg_addr_i, phyreg_wdata_i, phyreg_rdata_o;
	logic [7:0] tx_data_i, rx_data_o, rx_cmd_o;
	logic ulpi_data_oe_o, ulpi_dir_i, ulpi_nxt_i, ulpi_stp_o, exec_req_i, exec_ack_o;
	logic exec_aborted_o, tx_data_empty_i, tx_data_next_o, rx_data_valid_o;
	ulpi_instr_t instruction_i;

	logic h_req;	// Host values for the next falling edge.
	ulpi_instr_t h_instr;
	logic [7:0] h_addr, h_wdata;
	logic [7:0] fifo_q[$];	// TX FIFO contents.
	logic [7:0] pkt [0:15];	// Packet for the current transmit.
	int pkt_len;
	logic [8:0] bus_q[$];	// Bus events as {stp, byte}.
	logic [8:0] exp_q[$];
	logic [7:0] rx_q[$];	// Bytes from rx_data_o.
	logic got_abort;
	logic [7:0] got_rdata;
	logic [31:0] lfsr = 32'd68566;

	logic pmode = 1'b0;	// PHY is taking link bytes.
	logic [7:0] pcmd, paddr, pw, rd_val;
	int pcnt, pdly;
	int rd_phase = 0;	// 1 for turnaround and 2 for read data.
	logic pre_en = 1'b0;	// Answer reads with a USB receive.
	logic [8:0] inj_q[$];	// RX burst entries as {nxt, byte}.
	logic inj_on = 1'b0;
	logic [7:0] rf [0:63];	// Normal PHY registers.
	logic [7:0] ext_rf [0:255];	// Extended PHY registers.

	always #4 clk = ~clk;

	ulpi_link_top dut (
		.ulpi_clk(clk), .rst(rst), .ulpi_data_i(ulpi_data_i), .ulpi_data_o(ulpi_data_o),
		.ulpi_data_oe_o(ulpi_data_oe_o), .ulpi_dir_i(ulpi_dir_i), .ulpi_nxt_i(ulpi_nxt_i),
		.ulpi_stp_o(ulpi_stp_o), .instruction_i(instruction_i), .exec_req_i(exec_req_i),
		.exec_ack_o(exec_ack_o), .exec_aborted_o(exec_aborted_o),
		.phyreg_addr_i(phyreg_addr_i), .phyreg_wdata_i(phyreg_wdata_i),
		.phyreg_rdata_o(phyreg_rdata_o), .tx_data_i(tx_data_i),
		.tx_data_empty_i(tx_data_empty_i), .tx_data_next_o(tx_data_next_o),
		.rx_data_o(rx_data_o), .rx_data_valid_o(rx_data_valid_o), .rx_cmd_o(rx_cmd_o)
	);

	bind ulpi_link_top ulpi_link_checker chk (
		.clk_i(ulpi_clk), .rst_i(rst), .dir_i(ulpi_dir_i), .oe_i(ulpi_data_oe_o),
		.stp_i(ulpi_stp_o), .req_i(exec_req_i), .ack_i(exec_ack_o)
	);

	task automatic fail(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic expect_bit(input string name, input logic val, input logic want);
		assert (val == want)
			else fail($sformatf("error %s got %h expected %h", name, val, want));
	endtask

	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = {1'b0, lfsr[31:1]};
		if (b) lfsr = lfsr ^ 32'hA3000000;	// Galois taps 32,30,26,25.
		return b;
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] r;
		r = 8'h00;
		for (int i = 0; i < n; i++) r = {r[6:0], lfsr_bit()};	// One step per bit.
		return r;
	endfunction

	// Expected bus event idx of an operation as {stp, byte}.
	function automatic logic [8:0] exp_byte(input ulpi_instr_t ins, input int idx,
			input logic [7:0] addr, input logic [7:0] wdata);
		logic ext;
		ext = (ins.reg_v.addr == `ULPI_EXT_ADDR);
		if (ins.reg_v.op == op_transmit) begin
			if (idx == 0) return {1'b0, ins.tx_v.op, 2'b00, ins.tx_v.pid};	// TX CMD.
			if (pkt_len == 0) return {1'b1, `ULPI_ABORT_BYTE};	// Underrun.
			if (idx <= pkt_len) return {1'b0, pkt[idx-1]};
			return {1'b1, `ULPI_NOOP_BYTE};
		end
		if (idx == 0) return {1'b0, ins};	// REGW or REGR command.
		if (ext && idx == 1) return {1'b0, addr};
		if (idx == (ext ? 2 : 1)) return {1'b0, wdata};
		return {1'b1, `ULPI_NOOP_BYTE};	// Stop after write data.
	endfunction

	function automatic int exp_len(input ulpi_instr_t ins);
		logic ext;
		ext = (ins.reg_v.addr == `ULPI_EXT_ADDR);
		case (ins.reg_v.op)
			op_transmit: return (pkt_len == 0) ? 2 : pkt_len + 2;
			op_regwrite: return ext ? 4 : 3;
			op_regread: return ext ? 2 : 1;
			default: return 0;
		endcase
	endfunction

	// Drives inputs at the falling edge and samples outputs before the next rising edge.
	task automatic tick();
		logic ext;
		ulpi_op_e pop;
		@(negedge clk);
		exec_req_i = h_req;
		instruction_i = h_instr;
		phyreg_addr_i = h_addr;
		phyreg_wdata_i = h_wdata;
		tx_data_empty_i = (fifo_q.size() == 0);
		tx_data_i = tx_data_empty_i ? 8'h00 : fifo_q[0];	// Fall-through head.
		if (rd_phase != 0) begin
			ulpi_dir_i = 1'b1;
			ulpi_nxt_i = pre_en;
			ulpi_data_i = (rd_phase == 1) ? 8'h00 : (pre_en ? rand_bits(8) : rd_val);
			rd_phase = (rd_phase == 1) ? 2 : 0;
		end else if (inj_q.size() != 0) begin
			ulpi_dir_i = 1'b1;
			if (!inj_on) begin
				inj_on = 1'b1;	// Turnaround cycle first.
				ulpi_nxt_i = 1'b0;
				ulpi_data_i = 8'h00;
			end else begin
				{ulpi_nxt_i, ulpi_data_i} = inj_q.pop_front();
			end
		end else begin
			inj_on = 1'b0;
			ulpi_dir_i = 1'b0;
			ulpi_nxt_i = pmode && pdly == 0;
			ulpi_data_i = 8'h00;
		end
		#2;
		if (tx_data_next_o) void'(fifo_q.pop_front());
		if (rx_data_valid_o) rx_q.push_back(rx_data_o);
		ext = (pcmd[5:0] == `ULPI_EXT_ADDR);
		pop = ulpi_op_e'(pcmd[7:6]);
		if (ulpi_stp_o) begin
			bus_q.push_back({1'b1, ulpi_data_o});
			if (pmode && pop == op_regwrite) begin
				if (ext) ext_rf[paddr] = pw;
				else rf[pcmd[5:0]] = pw;
			end
			pmode = 1'b0;
		end else if (pmode && ulpi_data_oe_o && ulpi_nxt_i) begin
			bus_q.push_back({1'b0, ulpi_data_o});
			if (pcnt == 1 && ext) paddr = ulpi_data_o;
			if (pop == op_regwrite && pcnt == (ext ? 2 : 1)) pw = ulpi_data_o;
			if (pop == op_regread && pcnt == (ext ? 1 : 0)) begin
				pmode = 1'b0;	// Turn the bus for read data.
				rd_phase = 1;
				rd_val = ext ? ext_rf[paddr] : rf[pcmd[5:0]];
			end
			pcnt++;
			pdly = int'(rand_bits(2));
		end else if (pmode && pdly > 0) begin
			pdly--;
		end else if (!pmode && ulpi_data_oe_o && ulpi_data_o != 8'h00 && rd_phase == 0) begin
			pmode = 1'b1;	// Command byte since no opcode is zero.
			pcmd = ulpi_data_o;
			pcnt = 0;
			pdly = int'(rand_bits(2));
		end
	endtask

	task automatic run_op(input ulpi_instr_t ins, input logic [7:0] addr,
			input logic [7:0] wdata);
		int n;
		n = exp_len(ins);
		for (int i = 0; i < n; i++) exp_q.push_back(exp_byte(ins, i, addr, wdata));
		h_instr = ins;
		h_addr = addr;
		h_wdata = wdata;
		h_req = 1'b1;
		n = 0;
		tick();
		while (!exec_ack_o) begin
			n++;
			if (n > 300) fail("timeout waiting for exec_ack_o to rise");
			tick();
		end
		got_abort = exec_aborted_o;
		got_rdata = phyreg_rdata_o;
		repeat (2) begin
			tick();
			expect_bit("exec_ack_o", exec_ack_o, 1'b1);	// Held while exec_req_i is high.
		end
		h_req = 1'b0;
		n = 0;
		tick();
		while (exec_ack_o) begin
			n++;
			if (n > 20) fail("timeout waiting for exec_ack_o to fall");
			tick();
		end
		n = 0;
		while (exp_q.size() != 0 || bus_q.size() != 0) begin
			n++;
			if (n > 20) fail("expected bus bytes never appeared");
			tick();
		end
	endtask

	// Compares one bus event per clock with the reference.
	always @(posedge clk) begin : compare
		logic [8:0] got, want;
		if (bus_q.size() != 0) begin
			if (exp_q.size() == 0) fail("bus activity where none was expected");
			got = bus_q.pop_front();
			want = exp_q.pop_front();
			assert (got == want)
				else fail($sformatf("error ulpi_data_o/stp got %h expected %h", got, want));
		end
	end

	initial begin
		ulpi_instr_t ins;
		logic [7:0] a, ea, wd, cmd;
		logic [7:0] exp_rx[$];
		int n;
		rst = 1'b1;
		{ulpi_data_i, ulpi_dir_i, ulpi_nxt_i, exec_req_i, h_req} = '0;
		{phyreg_addr_i, phyreg_wdata_i, tx_data_i, h_addr, h_wdata} = '0;
		instruction_i = '0;
		h_instr = '0;
		tx_data_empty_i = 1'b1;
		for (int i = 0; i < 256; i++) ext_rf[i] = 8'(i * 37 + 5);	// Whole-address fill.
		for (int i = 0; i < 64; i++) rf[i] = 8'(i * 11 + 3);
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		tick();
		expect_bit("exec_ack_o", exec_ack_o, 1'b0);
		expect_bit("exec_aborted_o", exec_aborted_o, 1'b0);
		expect_bit("tx_data_next_o", tx_data_next_o, 1'b0);
		expect_bit("rx_data_valid_o", rx_data_valid_o, 1'b0);
		expect_bit("ulpi_stp_o", ulpi_stp_o, 1'b0);
		for (int k = 0; k < 6; k++) begin	// Register round trips.
			a = rand_bits(6);
			if (a[5:0] == `ULPI_EXT_ADDR) a = a ^ 8'h01;
			if (k[0]) a = {2'b00, `ULPI_EXT_ADDR};
			ea = rand_bits(8);
			wd = rand_bits(8);
			ins.reg_v.op = op_regwrite;
			ins.reg_v.addr = a[5:0];
			run_op(ins, ea, wd);
			ins.reg_v.op = op_regread;
			run_op(ins, ea, 8'h00);
			expect_bit("exec_aborted_o", got_abort, 1'b0);
			assert (got_rdata == wd)
				else fail($sformatf("error phyreg_rdata_o got %h expected %h", got_rdata, wd));
		end
		for (int t = 0; t < 4; t++) begin	// Transmits with the last one empty.
			pkt_len = (t == 3) ? 0 : 1 + int'(rand_bits(3));
			for (int i = 0; i < pkt_len; i++) begin
				pkt[i] = rand_bits(8);
				fifo_q.push_back(pkt[i]);
			end
			ins.tx_v.op = op_transmit;
			ins.tx_v.rsvd = 2'b00;
			a = rand_bits(4);
			ins.tx_v.pid = a[3:0];
			run_op(ins, 8'h00, 8'h00);
			assert (fifo_q.size() == 0) else fail("FIFO not drained by transmit");
		end
		for (int b = 0; b < 2; b++) begin	// Receive bursts.
			rx_q.delete();
			exp_rx.delete();
			cmd = rand_bits(8);
			inj_q.push_back({1'b0, cmd});
			n = 1 + int'(rand_bits(3));
			for (int i = 0; i < n; i++) begin
				exp_rx.push_back(rand_bits(8));
				inj_q.push_back({1'b1, exp_rx[i]});
			end
			n = 0;
			tick();
			while (inj_q.size() != 0 || ulpi_dir_i) begin
				n++;
				if (n > 50) fail("timeout waiting for RX burst to end");
				tick();
			end
			repeat (4) tick();
			assert (rx_cmd_o == cmd)
				else fail($sformatf("error rx_cmd_o got %h expected %h", rx_cmd_o, cmd));
			assert (rx_q.size() == exp_rx.size()) else fail("wrong number of RX data bytes");
			foreach (exp_rx[i]) begin
				assert (rx_q[i] == exp_rx[i])
					else fail($sformatf("error rx_data_o got %h expected %h", rx_q[i], exp_rx[i]));
			end
		end
		pre_en = 1'b1;	// Read lost to a USB receive.
		ins.reg_v.op = op_regread;
		ins.reg_v.addr = 6'h05;
		run_op(ins, 8'h00, 8'h00);
		expect_bit("exec_aborted_o", got_abort, 1'b1);
		pre_en = 1'b0;
		ins = '0;	// No-op expects no bus cycle.
		run_op(ins, 8'h00, 8'h00);
		repeat (4) tick();
		$display("No errors");
		$finish;
	end

endmodule

//--- bench/ulpi_link_checker.sv
`timescale 1ns/100ps

module ulpi_link_checker (
	input logic clk_i,
	input logic rst_i,
	input logic dir_i,	// PHY owns the bus.
	input logic oe_i,	// Link drive enable.
	input logic stp_i,
	input logic req_i,	// Host request.
	input logic ack_i	// Operation complete.
);

	// Link stays off the data pins while dir is high and for one cycle after it falls.
	no_contention: assert property (
		@(posedge clk_i) disable iff (rst_i) !(oe_i && (dir_i || $past(dir_i)))
	) else $error("link drove the data bus while the PHY owned it or during turnaround");

	// Stop is a single-cycle strobe.
	stp_one_cycle: assert property (
		@(posedge clk_i) disable iff (rst_i) stp_i |=> !stp_i
	) else $error("stp held for more than one cycle");

	// Four-phase rule on the host side.
	ack_needs_req: assert property (
		@(posedge clk_i) disable iff (rst_i) $rose(ack_i) |-> req_i
	) else $error("exec_ack_o rose without exec_req_i");

endmodule

//--- design/ulpi_link_if.sv
`timescale 1ns/100ps
`include "ulpi_settings.svh"

// PHY side of the bus as seen one cycle late.
interface ulpi_rx_bus_if;
	logic dir_q;	// Registered dir.
	logic nxt_q;	// Registered nxt.
	logic [`ULPI_DW-1:0] data_q;	// Registered data pins.
	logic turn;	// Registered dir just changed.

	modport arb (
		output dir_q, nxt_q, data_q, turn
	);
	modport rx (
		input dir_q, nxt_q, data_q, turn
	);
	modport tx (
		input dir_q, turn
	);
endinterface

// Register read hand-off between the two machines.
interface ulpi_regrd_if;
	logic req;	// Read address accepted by PHY.
	logic ack;	// Data captured or read lost.
	logic abort;	// Read preempted by USB receive.
	logic [`ULPI_DW-1:0] rdata;	// Register value.

	modport tx (
		output req,
		input ack, abort, rdata
	);
	modport rx (
		input req,
		output ack, abort, rdata
	);
endinterface

//--- design/ulpi_link_top.sv
`timescale 1ns/100ps
`include "ulpi_settings.svh"

module ulpi_link_top (
	input logic ulpi_clk,	// 60 MHz from the PHY.
	input logic rst,
	input logic [`ULPI_DW-1:0] ulpi_data_i,
	output logic [`ULPI_DW-1:0] ulpi_data_o,
	output logic ulpi_data_oe_o,
	input logic ulpi_dir_i,
	input logic ulpi_nxt_i,
	output logic ulpi_stp_o,
	input ulpi_pkg::ulpi_instr_t instruction_i,
	input logic exec_req_i,
	output logic exec_ack_o,
	output logic exec_aborted_o,
	input logic [`ULPI_DW-1:0] phyreg_addr_i,
	input logic [`ULPI_DW-1:0] phyreg_wdata_i,
	output logic [`ULPI_DW-1:0] phyreg_rdata_o,
	input logic [`ULPI_DW-1:0] tx_data_i,
	input logic tx_data_empty_i,
	output logic tx_data_next_o,
	output logic [`ULPI_DW-1:0] rx_data_o,
	output logic rx_data_valid_o,
	output logic [`ULPI_DW-1:0] rx_cmd_o
);

	logic [`ULPI_DW-1:0] tx_word;	// TX machine to arbiter.

	ulpi_rx_bus_if bus_if ();
	ulpi_regrd_if rd_if ();

	ulpi_turnaround u_turn (
		.ulpi_clk (ulpi_clk),
		.rst (rst),
		.ulpi_dir_i (ulpi_dir_i),
		.ulpi_nxt_i (ulpi_nxt_i),
		.ulpi_data_i (ulpi_data_i),
		.tx_word_i (tx_word),
		.ulpi_data_o (ulpi_data_o),
		.ulpi_data_oe_o (ulpi_data_oe_o),
		.bus (bus_if)
	);

	ulpi_tx_fsm u_tx (
		.ulpi_clk (ulpi_clk),
		.rst (rst),
		.ulpi_dir_i (ulpi_dir_i),
		.ulpi_nxt_i (ulpi_nxt_i),
		.instruction_i (instruction_i),
		.exec_req_i (exec_req_i),
		.exec_ack_o (exec_ack_o),
		.exec_aborted_o (exec_aborted_o),
		.phyreg_addr_i (phyreg_addr_i),
		.phyreg_wdata_i (phyreg_wdata_i),
		.phyreg_rdata_o (phyreg_rdata_o),
		.tx_data_i (tx_data_i),
		.tx_data_empty_i (tx_data_empty_i),
		.tx_data_next_o (tx_data_next_o),
		.tx_word_o (tx_word),
		.ulpi_stp_o (ulpi_stp_o),
		.bus (bus_if),
		.rd (rd_if)
	);

	ulpi_rx_fsm u_rx (
		.ulpi_clk (ulpi_clk),
		.rst (rst),
		.bus (bus_if),
		.rd (rd_if),
		.rx_data_o (rx_data_o),
		.rx_data_valid_o (rx_data_valid_o),
		.rx_cmd_o (rx_cmd_o)
	);

endmodule

//--- design/ulpi_pkg.sv
`include "ulpi_settings.svh"

package ulpi_pkg;

	// Top two bits of every instruction word.
	typedef enum logic [1:0] {
		op_special  = 2'b00,	// No-op.
		op_transmit = 2'b01,	// USB packet, PID in low nibble.
		op_regwrite = 2'b10,	// Register write.
		op_regread  = 2'b11	// Register read.
	} ulpi_op_e;

	// One instruction byte seen two ways.
	typedef union packed {
		struct packed {
			ulpi_op_e op;	// Opcode.
			logic [`ULPI_DW-3:0] addr;	// Register address, 2F means extended.
		} reg_v;
		struct packed {
			ulpi_op_e op;	// Opcode.
			logic [1:0] rsvd;	// Zero on the wire.
			logic [`ULPI_DW-5:0] pid;	// USB packet ID.
		} tx_v;
	} ulpi_instr_t;

	typedef enum logic [3:0] {
		st_tx_idle,	// Drive no-op, wait for a request.
		st_tx_pid,	// Drive TX command with PID.
		st_tx_data,	// Stream FIFO bytes.
		st_tx_underrun,	// FF with stp.
		st_tx_stop,	// Plain stp after a register write.
		st_tx_reg_addr,	// REGW or REGR command byte.
		st_tx_reg_extaddr,	// Extended address byte.
		st_tx_reg_wdata,	// Register write data.
		st_tx_rd_wait,	// Read handed to RX machine.
		st_tx_done	// Ack to the host.
	} tx_state_e;

	typedef enum logic [1:0] {
		st_rx_idle,	// RX CMD and USB data.
		st_rx_rd_data,	// Register read data on the bus.
		st_rx_rd_ack	// Ack held until req drops.
	} rx_state_e;

endpackage

//--- design/ulpi_rx_fsm.sv
`timescale 1ns/100ps
`include "ulpi_settings.svh"

module ulpi_rx_fsm (
	input logic ulpi_clk,
	input logic rst,
	ulpi_rx_bus_if.rx bus,
	ulpi_regrd_if.rx rd,
	output logic [`ULPI_DW-1:0] rx_data_o,	// USB data byte.
	output logic rx_data_valid_o,	// One pulse per byte.
	output logic [`ULPI_DW-1:0] rx_cmd_o	// Last RX CMD.
);
	import ulpi_pkg::*;

	rx_state_e state;
	logic rd_start;	// PHY took the bus for a pending read.
	logic rx_cycle;	// Ordinary PHY-owned cycle.

	assign rd_start = bus.turn & bus.dir_q & rd.req;
	assign rx_cycle = bus.dir_q & ~bus.turn & (state != st_rx_rd_data);

	always_ff @(posedge ulpi_clk) begin
		if (rst) begin
			state <= st_rx_idle;
			rd.ack <= 1'b0;
			rd.abort <= 1'b0;
			rx_data_valid_o <= 1'b0;
		end else begin
			rx_data_valid_o <= rx_cycle & bus.nxt_q;
			case (state)
				st_rx_idle: begin
					if (rd_start) begin
						if (bus.nxt_q) begin	// USB receive won the turnaround.
							rd.ack <= 1'b1;
							rd.abort <= 1'b1;
							state <= st_rx_rd_ack;
						end else begin
							state <= st_rx_rd_data;
						end
					end
				end
				st_rx_rd_data: begin
					rd.ack <= 1'b1;	// Data lands in rdata now.
					rd.abort <= 1'b0;
					state <= st_rx_rd_ack;
				end
				st_rx_rd_ack: begin
					if (!rd.req) begin
						rd.ack <= 1'b0;
						rd.abort <= 1'b0;
						state <= st_rx_idle;
					end
				end
				default: state <= st_rx_idle;
			endcase
		end
	end

	// Payload registers.
	always_ff @(posedge ulpi_clk) begin
		if (state == st_rx_rd_data) begin
			rd.rdata <= bus.data_q;
		end
		if (rx_cycle && bus.nxt_q) begin
			rx_data_o <= bus.data_q;
		end
		if (rx_cycle && !bus.nxt_q) begin
			rx_cmd_o <= bus.data_q;	// Line state and RX events.
		end
	end

endmodule

//--- design/ulpi_turnaround.sv
`timescale 1ns/100ps
`include "ulpi_settings.svh"

module ulpi_turnaround (
	input logic ulpi_clk,
	input logic rst,
	input logic ulpi_dir_i,	// PHY owns the bus when high.
	input logic ulpi_nxt_i,	// PHY throttle and RX data strobe.
	input logic [`ULPI_DW-1:0] ulpi_data_i,	// Data pins as driven by the PHY.
	input logic [`ULPI_DW-1:0] tx_word_i,	// Byte from the TX machine.
	output logic [`ULPI_DW-1:0] ulpi_data_o,	// Data pins as driven by the link.
	output logic ulpi_data_oe_o,	// Link drive enable.
	ulpi_rx_bus_if.arb bus
);

	logic link_owns;	// Link may drive this cycle.

	// Link drives only once dir has been low for a full cycle.
	assign link_owns = ~ulpi_dir_i & ~bus.dir_q;

	assign ulpi_data_oe_o = link_owns;
	assign ulpi_data_o = link_owns ? tx_word_i : '0;	// Park low when released.

	// Control side of the sampled bus.
	always_ff @(posedge ulpi_clk) begin
		if (rst) begin
			bus.dir_q <= 1'b0;	// Link owns the bus out of reset.
			bus.nxt_q <= 1'b0;
			bus.turn <= 1'b0;
		end else begin
			bus.dir_q <= ulpi_dir_i;
			bus.nxt_q <= ulpi_nxt_i;
			bus.turn <= ulpi_dir_i ^ bus.dir_q;	// High with the first new dir_q.
		end
	end

	// Data pins sampled every cycle.
	always_ff @(posedge ulpi_clk) begin
		bus.data_q <= ulpi_data_i;
	end

endmodule

//--- design/ulpi_tx_fsm.sv
`timescale 1ns/100ps
`include "ulpi_settings.svh"

module ulpi_tx_fsm (
	input logic ulpi_clk,
	input logic rst,
	input logic ulpi_dir_i,
	input logic ulpi_nxt_i,
	input ulpi_pkg::ulpi_instr_t instruction_i,	// Held by host until ack.
	input logic exec_req_i,	// Four-phase request.
	output logic exec_ack_o,	// Operation complete.
	output logic exec_aborted_o,	// Read lost or timed out.
	input logic [`ULPI_DW-1:0] phyreg_addr_i,	// Extended address.
	input logic [`ULPI_DW-1:0] phyreg_wdata_i,	// Register write data.
	output logic [`ULPI_DW-1:0] phyreg_rdata_o,	// Register read data.
	input logic [`ULPI_DW-1:0] tx_data_i,	// FIFO head, first word fall through.
	input logic tx_data_empty_i,
	output logic tx_data_next_o,	// FIFO pop.
	output logic [`ULPI_DW-1:0] tx_word_o,	// Byte for the bus.
	output logic ulpi_stp_o,
	ulpi_rx_bus_if.tx bus,
	ulpi_regrd_if.tx rd
);
	import ulpi_pkg::*;

	tx_state_e state;
	tx_state_e state_nxt;
	logic hold;	// Bus not ours this cycle.
	logic ext_addr;	// Extended register access.
	logic is_read;
	logic [`ULPI_RD_TMO_W-1:0] tmo_cnt;	// Read wait counter.
	logic tmo_hit;

	assign hold = ulpi_dir_i | bus.dir_q;	// Same rule as the output enable.
	assign ext_addr = (instruction_i.reg_v.addr == `ULPI_EXT_ADDR);
	assign is_read = (instruction_i.reg_v.op == op_regread);
	assign tmo_hit = (tmo_cnt == `ULPI_RD_TIMEOUT);
	assign exec_ack_o = (state == st_tx_done);

	always_comb begin
		state_nxt = state;
		case (state)
			st_tx_idle: begin
				if (exec_req_i && !rd.ack && !hold) begin	// Previous read fully closed.
					case (instruction_i.reg_v.op)
						op_transmit: state_nxt = st_tx_pid;
						op_regwrite: state_nxt = st_tx_reg_addr;
						op_regread: state_nxt = st_tx_reg_addr;
						default: state_nxt = st_tx_done;	// No bus cycle.
					endcase
				end
			end
			st_tx_pid: begin
				if (!hold && ulpi_nxt_i) begin
					state_nxt = tx_data_empty_i ? st_tx_underrun : st_tx_data;
				end
			end
			st_tx_data: begin
				if (!hold && tx_data_empty_i) begin	// Stop cycle is this one.
					state_nxt = st_tx_done;
				end
			end
			st_tx_underrun, st_tx_stop: begin
				if (!hold) begin
					state_nxt = st_tx_done;
				end
			end
			st_tx_reg_addr: begin
				if (!hold && ulpi_nxt_i) begin
					if (ext_addr) begin
						state_nxt = st_tx_reg_extaddr;
					end else begin
						state_nxt = is_read ? st_tx_rd_wait : st_tx_reg_wdata;
					end
				end
			end
			st_tx_reg_extaddr: begin
				if (!hold && ulpi_nxt_i) begin
					state_nxt = is_read ? st_tx_rd_wait : st_tx_reg_wdata;
				end
			end
			st_tx_reg_wdata: begin
				if (!hold && ulpi_nxt_i) begin
					state_nxt = st_tx_stop;
				end
			end
			st_tx_rd_wait: begin
				if (rd.ack || tmo_hit) begin	// PHY turnaround does not hold us.
					state_nxt = st_tx_done;
				end
			end
			st_tx_done: begin
				if (!exec_req_i) begin
					state_nxt = st_tx_idle;
				end
			end
			default: state_nxt = st_tx_idle;
		endcase
	end

	always_ff @(posedge ulpi_clk) begin
		if (rst) begin
			state <= st_tx_idle;
			rd.req <= 1'b0;
			exec_aborted_o <= 1'b0;
			tmo_cnt <= '0;
		end else begin
			state <= state_nxt;
			rd.req <= (state_nxt == st_tx_rd_wait);	// Drops the cycle after ack.
			if (state == st_tx_idle && state_nxt != st_tx_idle) begin
				exec_aborted_o <= 1'b0;	// New operation.
			end else if (state == st_tx_rd_wait && state_nxt == st_tx_done) begin
				exec_aborted_o <= rd.ack ? rd.abort : 1'b1;	// Timeout counts as abort.
			end
			if (state != st_tx_rd_wait || bus.turn) begin
				tmo_cnt <= '0;	// Restart once PHY turns the bus.
			end else if (!tmo_hit) begin
				tmo_cnt <= tmo_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge ulpi_clk) begin
		if (state == st_tx_rd_wait && rd.ack) begin
			phyreg_rdata_o <= rd.rdata;
		end
	end

	// Bus byte and stp follow the state.
	always_comb begin
		tx_word_o = `ULPI_NOOP_BYTE;
		ulpi_stp_o = 1'b0;
		tx_data_next_o = 1'b0;
		case (state)
			st_tx_pid: tx_word_o = {op_transmit, 2'b00, instruction_i.tx_v.pid};
			st_tx_data: begin
				if (tx_data_empty_i) begin
					ulpi_stp_o = ~hold;	// End of packet.
				end else begin
					tx_word_o = tx_data_i;
					tx_data_next_o = ulpi_nxt_i & ~hold;	// Pop on accept.
				end
			end
			st_tx_underrun: begin
				tx_word_o = `ULPI_ABORT_BYTE;
				ulpi_stp_o = ~hold;
			end
			st_tx_stop: ulpi_stp_o = ~hold;
			st_tx_reg_addr: tx_word_o = instruction_i;	// Opcode and address as is.
			st_tx_reg_extaddr: tx_word_o = phyreg_addr_i;
			st_tx_reg_wdata: tx_word_o = phyreg_wdata_i;
			default: tx_word_o = `ULPI_NOOP_BYTE;
		endcase
	end

endmodule

//--- include/ulpi_settings.svh
`ifndef ULPI_SETTINGS_SVH
`define ULPI_SETTINGS_SVH

// ULPI data bus width, one byte per clock in SDR mode.
`define ULPI_DW 8

// Address field value that selects the extended register path.
`define ULPI_EXT_ADDR 6'h2F

// Byte driven with stp when the transmit FIFO underruns.
`define ULPI_ABORT_BYTE 8'hFF

// Idle byte on the bus while the link has nothing to send.
`define ULPI_NOOP_BYTE 8'h00

// Cycles the TX machine waits for register read data.
`define ULPI_RD_TIMEOUT 6'd40

// Width of the read timeout counter.
`define ULPI_RD_TMO_W 6

`endif

//--- run.sh
#!/bin/sh
# Build and run the ULPI link testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ulpi_link -f src.f -o sim_tb

# The simulator exits non-zero on a failed check, the log decides.
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "No errors" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

//--- src.f
+incdir+include
design/ulpi_pkg.sv
design/ulpi_link_if.sv
design/ulpi_turnaround.sv
design/ulpi_tx_fsm.sv
design/ulpi_rx_fsm.sv
design/ulpi_link_top.sv
bench/ulpi_link_checker.sv
bench/tb_ulpi_link.sv
